// ==== drumPatterns.hex ====
// kind: 1 command, 2 expect sample
// columns: kind, cmd_t {op, node, value} as 24 bits, expected tap sample
// Zero membrane gives zero samples whatever the coefficients
2 000000 00000
2 000000 00000
1 402000 00000
1 801000 00000
2 000000 00000
2 000000 00000
2 000000 00000
// Strike at the tap, rho and eta zero
1 400000 00000
1 800000 00000
1 D40400 00000
2 000000 00000
2 000000 00800
2 000000 00C00
2 000000 01000
2 000000 01400
// Damped run, eta 0.125, then eta 0.25 in mid-run
1 802000 00000
1 D44000 00000
2 000000 01800
2 000000 07000
2 000000 09300
2 000000 0AB80
1 804000 00000
2 000000 0BB94
2 000000 0B8E6
2 000000 0ABD5
2 000000 099BE
// Second strike repeats the fresh damped run
1 802000 00000
1 D44000 00000
2 000000 085F5
2 000000 07000
2 000000 09300
2 000000 0AB80
2 000000 0BB94
// Diagonal neighbor strike, rho 0.25
1 800000 00000
1 404000 00000
1 E81000 00000
2 000000 0C4F5
2 000000 00000
2 000000 00200
2 000000 00600
2 000000 00780
2 000000 00380

// ==== verilog.f ====
+incdir+.
drumPkg.sv
meshNode.sv
meshGrid.sv
hostPort.sv
sampleTap.sv
drumTop.sv
drumTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= drumTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== drumTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module drumTb;

  import drumPkg::*;

  localparam int MaxRecords = 64;
  localparam int CyclesPerRecord = 200;
  localparam logic [23:0] KindCommand = 24'd1;
  localparam logic [23:0] KindExpect = 24'd2;

  logic    clk = 1'b0;
  logic    reset;
  cmd_t    cmd;
  logic    cmdReq;
  logic    cmdAck;
  sample_t sample;
  logic    sampleReq;
  logic    sampleAck;

  // Three words per record for kind, command word and expected sample
  logic [23:0] patternMem [0:3*MaxRecords-1];

  int          recordCount;
  logic        loaded;
  int          checkCount;
  int          errorCount;
  int          sampleIndex;
  int          coeffPending;
  logic [31:0] lfsrState;

  always #5 clk = ~clk;

  drumTop drumTop_i
  (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .cmdReq    (cmdReq),
    .cmdAck    (cmdAck),
    .sample    (sample),
    .sampleReq (sampleReq),
    .sampleAck (sampleAck)
  );

  // Galois form shifting right
  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0])
      next = next ^ 32'h80200003;
    return next;
  endfunction

  // 0 to 7 idle cycles from three LFSR bits
  task automatic idleRandomCycles();
    int count;
    count = 0;
    for (int b = 0; b < 3; b++)
    begin
      count = (count << 1) | int'(lfsrState[0]);
      lfsrState = lfsrStep(lfsrState);
    end
    repeat (count) @(posedge clk);
  endtask

  task automatic checkSample(input sample_t expected, input sample_t actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("Fail at %0t: sample %0d is %0d, expected %0d",
               $time, sampleIndex, actual, expected);
    end
  endtask

  task automatic checkCoeffEffect(input sample_t expected, input sample_t actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("Fail at %0t: sample %0d after coefficient change is %0d, expected %0d",
               $time, sampleIndex, actual, expected);
    end
  endtask

  task automatic receiveSample(input sample_t expected);
    @(negedge clk);
    while (!sampleReq)
      @(negedge clk);
    // First sample computed wholly with the new coefficients
    if (coeffPending == 1)
      checkCoeffEffect(expected, sample);
    else
      checkSample(expected, sample);
    if (coeffPending > 0)
      coeffPending--;
    sampleIndex++;
    idleRandomCycles();
    @(posedge clk);
    sampleAck <= 1'b1;
    @(negedge clk);
    while (sampleReq)
      @(negedge clk);
    idleRandomCycles();
    @(posedge clk);
    sampleAck <= 1'b0;
  endtask

  task automatic sendCommand(input cmd_t command);
    // Only while the grid is parked on a pending sample
    @(negedge clk);
    while (!sampleReq)
      @(negedge clk);
    @(posedge clk);
    cmd    <= command;
    cmdReq <= 1'b1;
    @(negedge clk);
    while (!cmdAck)
      @(negedge clk);
    @(posedge clk);
    cmdReq <= 1'b0;
    @(negedge clk);
    while (cmdAck)
      @(negedge clk);
    // Pending sample still uses the old values
    if (command.op == opSetRho || command.op == opSetEta)
      coeffPending = 2;
  endtask

  initial
  begin
    logic [23:0] kind;
    cmd_t        command;
    sample_t     expected;

    reset        = 1'b1;
    cmd          = '0;
    cmdReq       = 1'b0;
    sampleAck    = 1'b0;
    checkCount   = 0;
    errorCount   = 0;
    sampleIndex  = 0;
    coeffPending = 0;
    lfsrState    = 32'he898;
    loaded       = 1'b0;

    for (int i = 0; i < 3 * MaxRecords; i++)
      patternMem[i] = '0;
    $readmemh("drumPatterns.hex", patternMem);
    // A zero kind ends the list
    recordCount = 0;
    while (recordCount < MaxRecords && patternMem[3 * recordCount] != '0)
      recordCount++;
    loaded = 1'b1;

    repeat (5) @(posedge clk);
    reset <= 1'b0;

    if (recordCount == 0)
    begin
      errorCount++;
      $display("No records were found in drumPatterns.hex");
    end

    for (int i = 0; i < recordCount; i++)
    begin
      kind     = patternMem[3 * i];
      command  = cmd_t'(patternMem[3 * i + 1]);
      expected = patternMem[3 * i + 2][17:0];
      if (kind == KindCommand)
        sendCommand(command);
      else if (kind == KindExpect)
        receiveSample(expected);
      else
      begin
        errorCount++;
        $display("Record %0d has an unknown kind %0h", i, kind);
      end
    end

    repeat (2) @(posedge clk);
    $display("Records: %0d, checks: %0d, errors: %0d", recordCount, checkCount, errorCount);
    if (errorCount == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  // Watchdog sized from the record count
  initial
  begin
    wait (loaded === 1'b1);
    repeat (recordCount * CyclesPerRecord + 20) @(posedge clk);
    $display("Timeout: a handshake with the DUT never completed");
    $display("Records: %0d, checks: %0d, errors: %0d", recordCount, checkCount, errorCount);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== drumTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module drumTop
(
  input  logic             clk,
  input  logic             reset,
  input  drumPkg::cmd_t    cmd,
  input  logic             cmdReq,
  output logic             cmdAck,
  output drumPkg::sample_t sample,
  output logic             sampleReq,
  input  logic             sampleAck
);

  import drumPkg::*;

  coeff_t  coeff;
  strike_t strike;
  sample_t tapU;
  logic    updated;
  logic    advance;

  hostPort hostPort_i
  (
    .clk    (clk),
    .reset  (reset),
    .cmd    (cmd),
    .cmdReq (cmdReq),
    .cmdAck (cmdAck),
    .coeff  (coeff),
    .strike (strike)
  );

  meshGrid meshGrid_i
  (
    .clk     (clk),
    .reset   (reset),
    .coeff   (coeff),
    .strike  (strike),
    .advance (advance),
    .tapU    (tapU),
    .updated (updated)
  );

  // Output stage stalls the grid under back-pressure
  sampleTap sampleTap_i
  (
    .clk       (clk),
    .reset     (reset),
    .tapU      (tapU),
    .updated   (updated),
    .sample    (sample),
    .sampleReq (sampleReq),
    .sampleAck (sampleAck),
    .advance   (advance)
  );

endmodule

`default_nettype wire

// ==== sampleTap.sv ====
`timescale 1ns/10ps
`default_nettype none

module sampleTap
(
  input  logic             clk,
  input  logic             reset,
  input  drumPkg::sample_t tapU,
  input  logic             updated,
  output drumPkg::sample_t sample,
  output logic             sampleReq,
  input  logic             sampleAck,
  output logic             advance
);

  import drumPkg::*;

  typedef enum logic [1:0]
  {
    tapRun,
    tapOffer,
    tapRelease
  } tapState_t;

  tapState_t tapState;

  always_ff @(posedge clk)
  begin
    if (reset)
      tapState <= tapRun;
    else
    begin
      case (tapState)
        tapRun:
          if (updated)
            tapState <= tapOffer;
        // Wait for the consumer to take it
        tapOffer:
          if (sampleAck)
            tapState <= tapRelease;
        tapRelease:
          if (!sampleAck)
            tapState <= tapRun;
        default:
          tapState <= tapRun;
      endcase
    end
  end

  // Sample register loaded once per iteration
  always_ff @(posedge clk)
  begin
    if (tapState == tapRun && updated)
      sample <= tapU;
  end

  assign sampleReq = (tapState == tapOffer);
  // Grid runs only when no sample is outstanding
  assign advance = (tapState == tapRun);

endmodule

`default_nettype wire

// ==== hostPort.sv ====
`timescale 1ns/10ps
`default_nettype none

module hostPort
(
  input  logic             clk,
  input  logic             reset,
  input  drumPkg::cmd_t    cmd,
  input  logic             cmdReq,
  output logic             cmdAck,
  output drumPkg::coeff_t  coeff,
  output drumPkg::strike_t strike
);

  import drumPkg::*;

  typedef enum logic
  {
    ackLow,
    ackHigh
  } ackState_t;

  ackState_t ackState;

  logic reqMeta;
  logic reqSync;

  // Request comes from another domain
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      reqMeta <= 1'b0;
      reqSync <= 1'b0;
    end
    else
    begin
      reqMeta <= cmdReq;
      reqSync <= reqMeta;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ackState     <= ackLow;
      coeff        <= '0;
      strike.valid <= 1'b0;
    end
    else
    begin
      strike.valid <= 1'b0;
      case (ackState)
        ackLow:
          if (reqSync)
          begin
            // Command is stable while the request is up
            ackState <= ackHigh;
            case (cmd.op)
              opSetRho:
                coeff.rho <= cmd.value;
              opSetEta:
                coeff.eta <= cmd.value;
              opStrike:
              begin
                strike.valid     <= 1'b1;
                strike.node      <= cmd.node;
                strike.amplitude <= cmd.value;
              end
              default:
                ;
            endcase
          end
        ackHigh:
          if (!reqSync)
            ackState <= ackLow;
        default:
          ackState <= ackLow;
      endcase
    end
  end

  assign cmdAck = (ackState == ackHigh);

endmodule

`default_nettype wire

// ==== meshGrid.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "drum_consts.svh"

module meshGrid
(
  input  logic             clk,
  input  logic             reset,
  input  drumPkg::coeff_t  coeff,
  input  drumPkg::strike_t strike,
  input  logic             advance,
  output drumPkg::sample_t tapU,
  output logic             updated
);

  import drumPkg::*;

  sample_t uGrid       [`DRUM_ROWS][`DRUM_COLS];
  logic    nodeUpdated [`DRUM_ROWS][`DRUM_COLS];

  genvar r;
  genvar c;

  for (r = 0; r < `DRUM_ROWS; r++)
  begin : gRow
    for (c = 0; c < `DRUM_COLS; c++)
    begin : gCol
      localparam int NodeIndex = r * `DRUM_COLS + c;

      sample_t uNorth;
      sample_t uSouth;
      sample_t uEast;
      sample_t uWest;
      sample_t loadValue;

      // Neighbors outside the clamped rim read as zero
      if (r == 0)
      begin : gNorthRim
        assign uNorth = '0;
      end
      else
      begin : gNorthLink
        assign uNorth = uGrid[r-1][c];
      end

      if (r == `DRUM_ROWS - 1)
      begin : gSouthRim
        assign uSouth = '0;
      end
      else
      begin : gSouthLink
        assign uSouth = uGrid[r+1][c];
      end

      if (c == `DRUM_COLS - 1)
      begin : gEastRim
        assign uEast = '0;
      end
      else
      begin : gEastLink
        assign uEast = uGrid[r][c+1];
      end

      if (c == 0)
      begin : gWestRim
        assign uWest = '0;
      end
      else
      begin : gWestLink
        assign uWest = uGrid[r][c-1];
      end

      // Only the struck node gets the amplitude
      assign loadValue = (strike.node == nodeIdx_t'(NodeIndex)) ? strike.amplitude : '0;

      meshNode meshNode_i
      (
        .clk       (clk),
        .reset     (reset),
        .load      (strike.valid),
        .loadValue (loadValue),
        .uNorth    (uNorth),
        .uSouth    (uSouth),
        .uEast     (uEast),
        .uWest     (uWest),
        .coeff     (coeff),
        .advance   (advance),
        .u         (uGrid[r][c]),
        .updated   (nodeUpdated[r][c])
      );
    end
  end

  // All nodes step in lockstep, so node 0 speaks for the grid
  assign updated = nodeUpdated[0][0];
  assign tapU = uGrid[`DRUM_TAP_ROW][`DRUM_TAP_COL];

endmodule

`default_nettype wire

// ==== meshNode.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "drum_consts.svh"

module meshNode
(
  input  logic             clk,
  input  logic             reset,
  input  logic             load,
  input  drumPkg::sample_t loadValue,
  input  drumPkg::sample_t uNorth,
  input  drumPkg::sample_t uSouth,
  input  drumPkg::sample_t uEast,
  input  drumPkg::sample_t uWest,
  input  drumPkg::coeff_t  coeff,
  input  logic             advance,
  output drumPkg::sample_t u,
  output logic             updated
);

  import drumPkg::*;

  typedef enum logic [2:0]
  {
    stInit,
    stMul1,
    stMul2,
    stMul3,
    stUpdate
  } nodeState_t;

  nodeState_t state;

  // Displacement now and one iteration back
  sample_t uCur;
  sample_t uPrev;

  // Shared multiplier with registered operands
  sample_t multA;
  sample_t multB;
  sample_t product;
  logic signed [2*`DRUM_W-1:0] fullProduct;

  sample_t lapTerm;
  sample_t laplacian;
  sample_t oneMinusEta;

  assign fullProduct = multA * multB;
  // Shift right by 16 and keep 18 bits so overflow wraps
  assign product = fullProduct[`DRUM_W+15:16];

  assign laplacian = uNorth + uSouth + uEast + uWest - (uCur <<< 2);
  assign oneMinusEta = `DRUM_ONE - coeff.eta;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= stInit;
      uCur  <= '0;
      uPrev <= '0;
    end
    else if (load)
    begin
      // Strike restarts the node with a clean history
      state <= stInit;
      uCur  <= loadValue;
      uPrev <= '0;
    end
    else
    begin
      case (state)
        stInit:
          state <= stMul1;
        stMul1:
        begin
          multA <= coeff.rho;
          multB <= laplacian;
          // Held here while the sample is waiting
          if (advance)
            state <= stMul2;
        end
        stMul2:
        begin
          lapTerm <= product;
          multA   <= oneMinusEta;
          multB   <= uPrev;
          state   <= stMul3;
        end
        stMul3:
        begin
          multA <= oneMinusEta;
          multB <= lapTerm + (uCur <<< 1) - product;
          state <= stUpdate;
        end
        stUpdate:
        begin
          uPrev <= uCur;
          uCur  <= product;
          state <= stMul1;
        end
        default:
          state <= stInit;
      endcase
    end
  end

  // New displacement shows on the output during the update cycle
  assign u = (state == stUpdate) ? product : uCur;
  assign updated = (state == stUpdate);

endmodule

`default_nettype wire

// ==== drumPkg.sv ====
`default_nettype none

`include "drum_consts.svh"

package drumPkg;

  // Signed Q1.16 displacement or coefficient
  typedef logic signed [`DRUM_W-1:0] sample_t;

  // Row-major node number
  typedef logic [3:0] nodeIdx_t;

  // Host command opcodes
  typedef enum logic [1:0]
  {
    opIdle   = 2'd0,
    opSetRho = 2'd1,
    opSetEta = 2'd2,
    opStrike = 2'd3
  } cmdOp_t;

  // Host command word of 24 bits
  typedef struct packed
  {
    cmdOp_t   op;
    nodeIdx_t node;
    sample_t  value;
  } cmd_t;

  // Propagation and damping coefficients
  typedef struct packed
  {
    sample_t rho;
    sample_t eta;
  } coeff_t;

  // One-cycle strike request
  typedef struct packed
  {
    logic     valid;
    nodeIdx_t node;
    sample_t  amplitude;
  } strike_t;

endpackage

`default_nettype wire

// ==== drum_consts.svh ====
`ifndef DRUM_CONSTS_SVH
`define DRUM_CONSTS_SVH

// Grid size in nodes
// Nodes are numbered row-major from the north-west corner
`define DRUM_ROWS 4
`define DRUM_COLS 4

// Width of every displacement and coefficient value
`define DRUM_W 18

// Q1.16 representation of 1.0
`define DRUM_ONE 18'sh10000

// Node whose displacement leaves as the output sample
`define DRUM_TAP_ROW 1
`define DRUM_TAP_COL 1

`endif
